/* project.f */
src/snoop_cache_pkg.sv
src/cache_port_if.sv
src/cache_array.sv
src/cache_arbiter.sv
src/snoop_ctrl.sv
src/fill_ctrl.sv
src/snoop_cache_top.sv
test/snoop_cache_properties.sv
test/tb_snoop_cache.sv

/* run.sh */
#!/bin/sh
# Build and run the snooping cache testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_snoop_cache --Mdir build -o sim_snoop_cache -f project.f
./build/sim_snoop_cache +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "^test passed$" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure"
  exit 1
fi

/* test/tb_snoop_cache.sv */
/*
 * Testbench for the snooping data cache subsystem.
 * Drives fills and snoops on the falling edge, keeps a shadow model of
 * the line store and checks responses, data beats and invalidations
 * with concurrent assertions. Ready stalls come from a Galois LFSR.
 */
`timescale 1ns/1ps

module tb_snoop_cache;
  import snoop_cache_pkg::*;

  localparam int ClkPeriod = 4;
  localparam int NumSets   = 1 << index_w;
  localparam int NumRandom = 40;
  localparam int NumSnoops = 12 + NumRandom;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       bypass_i;
  logic                       ac_valid_i;
  logic                       ac_ready_o;
  logic [addr_w-1:0]          ac_addr_i;
  snoop_op_e                  ac_snoop_i;
  logic                       cr_valid_o;
  logic                       cr_ready_i;
  cr_resp_t                   cr_resp_o;
  logic                       cd_valid_o;
  logic                       cd_ready_i;
  logic [beat_w-1:0]          cd_data_o;
  logic                       cd_last_o;
  logic                       fill_valid_i;
  logic [addr_w-1:0]          fill_addr_i;
  logic [$clog2(n_ways)-1:0]  fill_way_i;
  logic [line_w-1:0]          fill_data_i;
  logic                       fill_dirty_i;
  logic                       fill_shared_i;
  logic                       fill_busy_o;
  logic                       invalidate_o;
  logic [addr_w-1:0]          invalidate_addr_o;
  logic                       snoop_busy_o;

  // shadow model of the line store
  logic [tag_w-1:0]  m_tag   [n_ways][NumSets];
  logic [line_w-1:0] m_data  [n_ways][NumSets];
  line_flags_t       m_flags [n_ways][NumSets];

  cr_resp_t          exp_resp;
  logic [line_w-1:0] exp_line;
  logic [beat_w-1:0] exp_beat;
  logic              exp_inv;
  logic [addr_w-1:0] exp_inv_addr;
  logic              inv_seen;
  logic              beat_idx;
  logic [31:0]       lfsr_q = 32'he5b6_32df;
  int                resp_errs = 0;
  int                data_errs = 0;
  int                ctrl_errs = 0;

  snoop_cache_top #(.NumWays(n_ways)) snoop_cache_top_inst (.*);

  assign exp_beat = beat_idx ? exp_line[line_w-1-:beat_w] : exp_line[beat_w-1:0];

  resp_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cr_valid_o && cr_ready_i |-> cr_resp_o == exp_resp)
    else begin
      resp_errs++;
      $display("ERR %0t cr_resp_o expected %b actual %b", $time, $sampled(exp_resp),
               $sampled(cr_resp_o));
    end

  beat_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cd_valid_o && cd_ready_i |-> cd_data_o == exp_beat)
    else begin
      data_errs++;
      $display("ERR %0t cd_data_o expected %h actual %h", $time, $sampled(exp_beat),
               $sampled(cd_data_o));
    end

  no_data_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cd_valid_o |-> exp_resp.data_transfer)
    else begin
      ctrl_errs++;
      $display("data beat offered for a response without data_transfer at %0t", $time);
    end

  inv_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cr_valid_o && cr_ready_i |-> inv_seen == exp_inv)
    else begin
      ctrl_errs++;
      $display("ERR %0t invalidate_o expected %b actual %b", $time, $sampled(exp_inv),
               $sampled(inv_seen));
    end

  inv_addr_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    invalidate_o |-> invalidate_addr_o == exp_inv_addr)
    else begin
      ctrl_errs++;
      $display("ERR %0t invalidate_addr_o expected %h actual %h", $time,
               $sampled(exp_inv_addr), $sampled(invalidate_addr_o));
    end

  // fill busy rises after the strobe and clears once the store is free
  fill_busy_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_valid_i |=> fill_busy_o)
    else begin
      ctrl_errs++;
      $display("ERR %0t fill_busy_o expected 1 actual %b", $time, $sampled(fill_busy_o));
    end

  fill_busy_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_busy_o && !snoop_busy_o |=> !fill_busy_o)
    else begin
      ctrl_errs++;
      $display("ERR %0t fill_busy_o expected 0 actual %b", $time, $sampled(fill_busy_o));
    end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic random_line(output logic [line_w-1:0] line);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      rand_bits(32, r);
      line[32*i+:32] = r;
    end
  endtask

  function automatic logic [tag_w-1:0] pick_tag(input logic sel);
    return sel ? tag_w'(24'h00_0b22) : tag_w'(24'h00_0a11);
  endfunction

  task automatic wait_fill_idle();
    while (fill_busy_o) @(negedge clk_i);
  endtask

  // set up the model and fill payload in the way that already holds the tag
  task automatic prepare_fill(input logic [31:0] addr, input int way_in,
                              input logic [line_w-1:0] data, input logic f_dirty,
                              input logic f_shared);
    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tag;
    int                 way;
    idx = addr[4+:index_w];
    tag = addr[4+index_w+:tag_w];
    way = way_in;
    for (int w = 0; w < n_ways; w++) begin
      if (w != way_in && m_flags[w][idx].valid && m_tag[w][idx] == tag) way = w;
    end
    m_tag[way][idx]   = tag;
    m_data[way][idx]  = data;
    m_flags[way][idx] = '{valid: 1'b1, dirty: f_dirty, shared: f_shared};
    fill_addr_i   = addr;
    fill_way_i    = way[0];
    fill_data_i   = data;
    fill_dirty_i  = f_dirty;
    fill_shared_i = f_shared;
  endtask

  task automatic send_fill(input logic [31:0] addr, input int way,
                           input logic [line_w-1:0] data, input logic f_dirty,
                           input logic f_shared);
    wait_fill_idle();
    prepare_fill(addr, way, data, f_dirty, f_shared);
    fill_valid_i = 1'b1;
    @(negedge clk_i);
    fill_valid_i = 1'b0;
    wait_fill_idle();
  endtask

  // expected response from the snoop rules and model update on a hit
  task automatic predict(input logic [31:0] addr, input logic [3:0] op);
    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tag;
    int                 hw;
    idx = addr[4+:index_w];
    tag = addr[4+index_w+:tag_w];
    hw = -1;
    exp_resp = '0;
    exp_line = '0;
    exp_inv = 1'b0;
    exp_inv_addr = {tag, idx, 4'h0};
    for (int w = 0; w < n_ways; w++) begin
      if (m_flags[w][idx].valid && m_tag[w][idx] == tag) hw = w;
    end
    if (bypass_i) return;
    if (!(op inside {READ_ONCE, READ_SHARED, READ_UNIQUE, CLEAN_INVALID})) begin
      exp_resp.error = 1'b1;
      return;
    end
    if (hw < 0) return;
    exp_line = m_data[hw][idx];
    exp_resp.data_transfer = 1'b1;
    case (op)
      READ_ONCE: exp_resp.is_shared = m_flags[hw][idx].shared;
      READ_SHARED: begin
        exp_resp.is_shared = 1'b1;
        m_flags[hw][idx].shared = 1'b1;
      end
      default: begin
        exp_resp.pass_dirty = m_flags[hw][idx].dirty;
        if (op == CLEAN_INVALID) exp_resp.data_transfer = m_flags[hw][idx].dirty;
        exp_inv = 1'b1;
        m_flags[hw][idx] = '0;
      end
    endcase
  endtask

  task automatic run_snoop(input logic [31:0] addr, input logic [3:0] op,
                           input logic with_fill);
    logic        cr_fire;
    logic        cd_fire;
    logic        last_beat;
    logic        done;
    logic [31:0] r;
    wait_fill_idle();
    predict(addr, op);
    inv_seen = 1'b0;
    beat_idx = 1'b0;
    ac_valid_i = 1'b1;
    ac_addr_i = addr;
    ac_snoop_i = snoop_op_e'(op);
    while (!ac_ready_o) @(negedge clk_i);
    // fill strobe lands on the accept edge
    fill_valid_i = with_fill;
    @(negedge clk_i);
    ac_valid_i = 1'b0;
    fill_valid_i = 1'b0;
    done = 1'b0;
    while (!done) begin
      if (invalidate_o) inv_seen = 1'b1;
      rand_bits(1, r);
      cr_ready_i = r[0];
      rand_bits(1, r);
      cd_ready_i = r[0];
      cr_fire = cr_valid_o & cr_ready_i;
      cd_fire = cd_valid_o & cd_ready_i;
      last_beat = cd_last_o;
      @(negedge clk_i);
      if (cd_fire) beat_idx = ~beat_idx;
      done = (cr_fire && !exp_resp.data_transfer) || (cd_fire && last_beat);
    end
    cr_ready_i = 1'b0;
    cd_ready_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NumSnoops * 200 * ClkPeriod);
    $display("timeout: snoop sequence still running after %0d cycles", NumSnoops * 200);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [31:0]       r_idx;
    logic [31:0]       r_tag;
    logic [31:0]       r_op;
    logic [31:0]       r_fill;
    logic [31:0]       r_mask;
    logic [31:0]       r_way;
    logic [31:0]       r_flags;
    logic [31:0]       addr;
    logic [3:0]        op;
    logic [line_w-1:0] line;
    int                total;
    rst_ni = 1'b0;
    bypass_i = 1'b0;
    ac_valid_i = 1'b0;
    ac_addr_i = '0;
    ac_snoop_i = READ_ONCE;
    cr_ready_i = 1'b0;
    cd_ready_i = 1'b0;
    fill_valid_i = 1'b0;
    fill_addr_i = '0;
    fill_way_i = '0;
    fill_data_i = '0;
    fill_dirty_i = 1'b0;
    fill_shared_i = 1'b0;
    for (int w = 0; w < n_ways; w++) begin
      for (int s = 0; s < NumSets; s++) begin
        m_flags[w][s] = '0;
      end
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // never filled
    run_snoop(32'h0000_5470, READ_ONCE, 1'b0);
    run_snoop(32'h0000_5470, READ_UNIQUE, 1'b0);
    // clean unshared line read twice
    send_fill(32'h0000_1230, 0, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 1'b0, 1'b0);
    run_snoop(32'h0000_1230, READ_ONCE, 1'b0);
    run_snoop(32'h0000_1230, READ_ONCE, 1'b0);
    run_snoop(32'h0000_1230, READ_SHARED, 1'b0);
    run_snoop(32'h0000_1230, READ_ONCE, 1'b0);
    // dirty line taken unique and clean line cleaned
    send_fill(32'h0000_2250, 1, 128'hdead_beef_0000_1111_2222_3333_cafe_f00d, 1'b1, 1'b0);
    run_snoop(32'h0000_2250, READ_UNIQUE, 1'b0);
    run_snoop(32'h0000_2250, READ_ONCE, 1'b0);
    send_fill(32'h0000_3360, 0, 128'h5555_aaaa_5555_aaaa_0f0f_f0f0_0f0f_f0f0, 1'b0, 1'b0);
    run_snoop(32'h0000_3360, CLEAN_INVALID, 1'b0);
    run_snoop(32'h0000_3360, READ_ONCE, 1'b0);
    // unsupported code and then bypass
    run_snoop(32'h0000_1230, 4'hf, 1'b0);
    bypass_i = 1'b1;
    run_snoop(32'h0000_1230, READ_SHARED, 1'b0);
    bypass_i = 1'b0;

    // random snoops with fills to another set in the accept cycle
    for (int n = 0; n < NumRandom; n++) begin
      rand_bits(4, r_idx);
      rand_bits(1, r_tag);
      rand_bits(3, r_op);
      rand_bits(1, r_fill);
      addr = {pick_tag(r_tag[0]), r_idx[3:0], 4'h0};
      case (r_op[2:0])
        3'd2, 3'd5: op = READ_SHARED;
        3'd3: op = READ_UNIQUE;
        3'd4: op = CLEAN_INVALID;
        3'd7: op = 4'hc;
        default: op = READ_ONCE;
      endcase
      if (r_fill[0]) begin
        rand_bits(4, r_mask);
        rand_bits(1, r_tag);
        rand_bits(1, r_way);
        rand_bits(2, r_flags);
        random_line(line);
        wait_fill_idle();
        prepare_fill({pick_tag(r_tag[0]), r_idx[3:0] ^ (r_mask[3:0] | 4'h1), 4'h0},
                     int'(r_way[0]), line, r_flags[1], r_flags[0]);
      end
      run_snoop(addr, op, r_fill[0]);
    end
    wait_fill_idle();
    repeat (4) @(negedge clk_i);

    total = resp_errs + data_errs + ctrl_errs +
            int'(snoop_cache_top_inst.snoop_cache_properties_inst.fail_cnt);
    $display("errors: response %0d, data %0d, control %0d, protocol %0d", resp_errs,
             data_errs, ctrl_errs, snoop_cache_top_inst.snoop_cache_properties_inst.fail_cnt);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* test/snoop_cache_properties.sv */
/*
 * Protocol assertions for the snooping cache top level, attached by bind.
 * Checks the valid/ready channels, the accept window, the beat order and
 * that an invalidation only follows an invalidating snoop.
 */
`timescale 1ns/1ps

module snoop_cache_properties (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic                               bypass_i,
  input logic                               ac_valid_i,
  input logic                               ac_ready_o,
  input logic [snoop_cache_pkg::addr_w-1:0] ac_addr_i,
  input snoop_cache_pkg::snoop_op_e         ac_snoop_i,
  input logic                               cr_valid_o,
  input logic                               cr_ready_i,
  input snoop_cache_pkg::cr_resp_t          cr_resp_o,
  input logic                               cd_valid_o,
  input logic                               cd_ready_i,
  input logic [snoop_cache_pkg::beat_w-1:0] cd_data_o,
  input logic                               cd_last_o,
  input logic                               invalidate_o,
  input logic                               snoop_busy_o
);
  import snoop_cache_pkg::*;

  int unsigned fail_cnt = 0;
  logic        inv_allowed_q;

  // last accepted snoop may invalidate a line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inv_allowed_q <= 1'b0;
    end else if (ac_valid_i && ac_ready_o) begin
      inv_allowed_q <= !bypass_i && (ac_snoop_i inside {READ_UNIQUE, CLEAN_INVALID});
    end
  end

  ac_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ac_valid_i && !ac_ready_o |=> ac_valid_i && $stable(ac_addr_i) && $stable(ac_snoop_i))
    else begin
      fail_cnt++;
      $error("address channel dropped valid or changed payload before ready");
    end

  cr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cr_valid_o && !cr_ready_i |=> cr_valid_o && $stable(cr_resp_o))
    else begin
      fail_cnt++;
      $error("response channel dropped valid or changed payload before ready");
    end

  cd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cd_valid_o && !cd_ready_i |=> cd_valid_o && $stable(cd_data_o) && $stable(cd_last_o))
    else begin
      fail_cnt++;
      $error("data channel dropped valid or changed payload before ready");
    end

  ready_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ac_ready_o && snoop_busy_o))
    else begin
      fail_cnt++;
      $error("snoop accepted while the controller is busy");
    end

  first_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cd_valid_o) |-> !cd_last_o)
    else begin
      fail_cnt++;
      $error("first data beat marked as last");
    end

  second_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cd_valid_o && cd_ready_i && !cd_last_o |=> cd_valid_o && cd_last_o)
    else begin
      fail_cnt++;
      $error("second data beat missing or not marked as last");
    end

  inv_after_op: assert property (@(posedge clk_i) disable iff (!rst_ni)
    invalidate_o |-> inv_allowed_q)
    else begin
      fail_cnt++;
      $error("invalidation without an invalidating snoop");
    end

endmodule

bind snoop_cache_top snoop_cache_properties snoop_cache_properties_inst (.*);

/* src/snoop_cache_top.sv */
/*
 * Top level of the snooping data cache subsystem.
 * Connects the snoop and fill controllers through the fixed-priority
 * arbiter to the line store. All outer channels are plain ports.
 */
`timescale 1ns/1ps

module snoop_cache_top #(
  parameter int unsigned NumWays = snoop_cache_pkg::n_ways
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               bypass_i,
  input  logic                               ac_valid_i,
  output logic                               ac_ready_o,
  input  logic [snoop_cache_pkg::addr_w-1:0] ac_addr_i,
  input  snoop_cache_pkg::snoop_op_e         ac_snoop_i,
  output logic                               cr_valid_o,
  input  logic                               cr_ready_i,
  output snoop_cache_pkg::cr_resp_t          cr_resp_o,
  output logic                               cd_valid_o,
  input  logic                               cd_ready_i,
  output logic [snoop_cache_pkg::beat_w-1:0] cd_data_o,
  output logic                               cd_last_o,
  input  logic                               fill_valid_i,
  input  logic [snoop_cache_pkg::addr_w-1:0] fill_addr_i,
  input  logic [$clog2(NumWays)-1:0]         fill_way_i,
  input  logic [snoop_cache_pkg::line_w-1:0] fill_data_i,
  input  logic                               fill_dirty_i,
  input  logic                               fill_shared_i,
  output logic                               fill_busy_o,
  output logic                               invalidate_o,
  output logic [snoop_cache_pkg::addr_w-1:0] invalidate_addr_o,
  output logic                               snoop_busy_o
);

  cache_port_if #(.NumWays(NumWays)) snoop_port ();
  cache_port_if #(.NumWays(NumWays)) fill_port ();
  cache_port_if #(.NumWays(NumWays)) array_port ();

  snoop_ctrl #(.NumWays(NumWays)) snoop_ctrl_inst (
    .clk_i, .rst_ni, .bypass_i,
    .ac_valid_i, .ac_ready_o, .ac_addr_i, .ac_snoop_i,
    .cr_valid_o, .cr_ready_i, .cr_resp_o,
    .cd_valid_o, .cd_ready_i, .cd_data_o, .cd_last_o,
    .invalidate_o, .invalidate_addr_o,
    .busy_o (snoop_busy_o),
    .mem    (snoop_port.requester)
  );

  fill_ctrl #(.NumWays(NumWays)) fill_ctrl_inst (
    .clk_i, .rst_ni,
    .fill_valid_i, .fill_addr_i, .fill_way_i,
    .fill_data_i, .fill_dirty_i, .fill_shared_i,
    .busy_o (fill_busy_o),
    .mem    (fill_port.requester)
  );

  cache_arbiter #(.NumWays(NumWays)) cache_arbiter_inst (
    .clk_i, .rst_ni,
    .snoop_if (snoop_port.arbiter),
    .fill_if  (fill_port.arbiter),
    .array_if (array_port.requester)
  );

  cache_array #(.NumWays(NumWays)) cache_array_inst (
    .clk_i, .rst_ni,
    .port_i (array_port.arbiter)
  );

endmodule

/* src/fill_ctrl.sv */
/*
 * Fill controller standing in for the core-side miss path.
 * A fill strobe is captured and written as a full line, with tag and
 * flags, into the chosen way once the store grants the request.
 */
`timescale 1ns/1ps

module fill_ctrl #(
  parameter int unsigned NumWays = snoop_cache_pkg::n_ways
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               fill_valid_i,
  input  logic [snoop_cache_pkg::addr_w-1:0] fill_addr_i,
  input  logic [$clog2(NumWays)-1:0]         fill_way_i,
  input  logic [snoop_cache_pkg::line_w-1:0] fill_data_i,
  input  logic                               fill_dirty_i,
  input  logic                               fill_shared_i,
  output logic                               busy_o,
  cache_port_if.requester                    mem
);
  import snoop_cache_pkg::*;

  logic               pending_q;
  logic [addr_w-1:0]  addr_q;
  logic [NumWays-1:0] way_mask_q;
  logic [line_w-1:0]  data_q;
  logic               dirty_q;
  logic               shared_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (fill_valid_i) begin
      pending_q <= 1'b1;
    end else if (mem.gnt) begin
      pending_q <= 1'b0;
    end
  end

  // fill payload, way number turned into a one-hot mask
  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      addr_q     <= fill_addr_i;
      way_mask_q <= NumWays'(1) << fill_way_i;
      data_q     <= fill_data_i;
      dirty_q    <= fill_dirty_i;
      shared_q   <= fill_shared_i;
    end
  end

  assign busy_o              = pending_q;
  assign mem.req             = pending_q;
  assign mem.we              = 1'b1;
  assign mem.index           = addr_q[4+:index_w];
  assign mem.tag             = addr_q[4+index_w+:tag_w];
  assign mem.way_mask        = way_mask_q;
  assign mem.wdata           = data_q;
  assign mem.wflags          = '{valid: 1'b1, dirty: dirty_q, shared: shared_q};
  assign mem.data_only_flags = 1'b0;

endmodule

/* src/snoop_ctrl.sv */
/*
 * Snoop controller. Accepts snoops on the address channel, looks the
 * line up in the store, updates its flags where the opcode asks for it
 * and answers with a response and, on data_transfer, two 64-bit beats.
 */
`timescale 1ns/1ps

module snoop_ctrl #(
  parameter int unsigned NumWays = snoop_cache_pkg::n_ways
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                bypass_i,
  input  logic                                ac_valid_i,
  output logic                                ac_ready_o,
  input  logic [snoop_cache_pkg::addr_w-1:0]  ac_addr_i,
  input  snoop_cache_pkg::snoop_op_e          ac_snoop_i,
  output logic                                cr_valid_o,
  input  logic                                cr_ready_i,
  output snoop_cache_pkg::cr_resp_t           cr_resp_o,
  output logic                                cd_valid_o,
  input  logic                                cd_ready_i,
  output logic [snoop_cache_pkg::beat_w-1:0]  cd_data_o,
  output logic                                cd_last_o,
  output logic                                invalidate_o,
  output logic [snoop_cache_pkg::addr_w-1:0]  invalidate_addr_o,
  output logic                                busy_o,
  cache_port_if.requester                     mem
);
  import snoop_cache_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVAL,
    UPDATE_SHARED,
    INVALIDATE,
    SEND_CR,
    SEND_CD
  } state_e;

  state_e state_q, state_d;
  cr_resp_t resp_q, resp_d;
  logic beat_q, beat_d;

  // request payload and captured line
  logic [index_w-1:0] index_q;
  logic [tag_w-1:0]   tag_q;
  snoop_op_e          op_q;
  logic [NumWays-1:0] hit_way_q;
  logic               dirty_q;
  logic [line_w-1:0]  line_q;

  logic              hit;
  logic              hit_dirty;
  logic              hit_shared;
  logic [line_w-1:0] hit_line;
  logic              supported;

  always_comb begin
    hit_dirty  = 1'b0;
    hit_shared = 1'b0;
    hit_line   = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (mem.hit_way[w]) begin
        hit_dirty  = mem.rflags[w].dirty;
        hit_shared = mem.rflags[w].shared;
        hit_line   = mem.rdata[w];
      end
    end
  end

  assign hit = |mem.hit_way;
  assign supported = ac_snoop_i inside {READ_ONCE, READ_SHARED, READ_UNIQUE, CLEAN_INVALID};

  always_comb begin
    state_d = state_q;
    resp_d  = resp_q;
    beat_d  = beat_q;
    case (state_q)
      IDLE: begin
        beat_d = 1'b0;
        resp_d = '0;
        if (ac_valid_i) begin
          if (bypass_i) begin
            state_d = SEND_CR;
          end else if (!supported) begin
            resp_d.error = 1'b1;
            state_d = SEND_CR;
          end else begin
            state_d = LOOKUP;
          end
        end
      end
      LOOKUP: begin
        if (mem.gnt) begin
          state_d = EVAL;
        end
      end
      EVAL: begin
        if (mem.rvalid) begin
          state_d = SEND_CR;
          if (hit) begin
            resp_d.data_transfer = 1'b1;
            case (op_q)
              READ_ONCE: resp_d.is_shared = hit_shared;
              READ_SHARED: begin
                resp_d.is_shared = 1'b1;
                state_d = UPDATE_SHARED;
              end
              READ_UNIQUE: begin
                resp_d.pass_dirty = hit_dirty;
                state_d = INVALIDATE;
              end
              default: begin
                // clean invalid only moves dirty data
                resp_d.data_transfer = hit_dirty;
                resp_d.pass_dirty = hit_dirty;
                state_d = INVALIDATE;
              end
            endcase
          end
        end
      end
      UPDATE_SHARED, INVALIDATE: begin
        if (mem.gnt) begin
          state_d = SEND_CR;
        end
      end
      SEND_CR: begin
        if (cr_ready_i) begin
          state_d = resp_q.data_transfer ? SEND_CD : IDLE;
        end
      end
      SEND_CD: begin
        if (cd_ready_i) begin
          beat_d = ~beat_q;
          if (beat_q) begin
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      resp_q  <= '0;
      beat_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      resp_q  <= resp_d;
      beat_q  <= beat_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && ac_valid_i) begin
      index_q <= ac_addr_i[4+:index_w];
      tag_q   <= ac_addr_i[4+index_w+:tag_w];
      op_q    <= ac_snoop_i;
    end
    if (state_q == EVAL && mem.rvalid) begin
      hit_way_q <= mem.hit_way;
      dirty_q   <= hit_dirty;
      line_q    <= hit_line;
    end
  end

  // store requests, flag writes leave data and tag alone
  always_comb begin
    mem.req             = state_q inside {LOOKUP, UPDATE_SHARED, INVALIDATE};
    mem.we              = state_q != LOOKUP;
    mem.index           = index_q;
    mem.tag             = tag_q;
    mem.way_mask        = hit_way_q;
    mem.wdata           = line_q;
    mem.data_only_flags = 1'b1;
    mem.wflags          = '0;
    if (state_q == UPDATE_SHARED) begin
      mem.wflags = '{valid: 1'b1, dirty: dirty_q, shared: 1'b1};
    end
  end

  assign ac_ready_o        = state_q == IDLE;
  assign busy_o            = state_q != IDLE;
  assign cr_valid_o        = state_q == SEND_CR;
  assign cr_resp_o         = resp_q;
  assign cd_valid_o        = state_q == SEND_CD;
  assign cd_last_o         = beat_q;
  assign cd_data_o         = beat_q ? line_q[line_w-1-:beat_w] : line_q[beat_w-1:0];
  assign invalidate_o      = (state_q == INVALIDATE) & mem.gnt;
  assign invalidate_addr_o = {tag_q, index_q, 4'b0000};

endmodule

/* src/cache_arbiter.sv */
/*
 * Fixed-priority arbiter in front of the line store.
 * The snoop side wins over the fill side. Read results go back only
 * to the side that issued the read one cycle earlier.
 */
`timescale 1ns/1ps

module cache_arbiter #(
  parameter int unsigned NumWays = snoop_cache_pkg::n_ways
) (
  input logic            clk_i,
  input logic            rst_ni,
  cache_port_if.arbiter   snoop_if,
  cache_port_if.arbiter   fill_if,
  cache_port_if.requester array_if
);

  logic snoop_rd_q;

  assign snoop_if.gnt = snoop_if.req & array_if.gnt;
  assign fill_if.gnt  = fill_if.req & ~snoop_if.req & array_if.gnt;

  // forward the winner's fields
  always_comb begin
    array_if.req = snoop_if.req | fill_if.req;
    if (snoop_if.req) begin
      array_if.we              = snoop_if.we;
      array_if.index           = snoop_if.index;
      array_if.tag             = snoop_if.tag;
      array_if.way_mask        = snoop_if.way_mask;
      array_if.wdata           = snoop_if.wdata;
      array_if.wflags          = snoop_if.wflags;
      array_if.data_only_flags = snoop_if.data_only_flags;
    end else begin
      array_if.we              = fill_if.we;
      array_if.index           = fill_if.index;
      array_if.tag             = fill_if.tag;
      array_if.way_mask        = fill_if.way_mask;
      array_if.wdata           = fill_if.wdata;
      array_if.wflags          = fill_if.wflags;
      array_if.data_only_flags = fill_if.data_only_flags;
    end
  end

  // owner of the read in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      snoop_rd_q <= 1'b0;
    end else begin
      snoop_rd_q <= snoop_if.req & ~snoop_if.we;
    end
  end

  assign snoop_if.rvalid  = array_if.rvalid & snoop_rd_q;
  assign fill_if.rvalid   = array_if.rvalid & ~snoop_rd_q;
  assign snoop_if.hit_way = array_if.hit_way & {NumWays{snoop_rd_q}};
  assign fill_if.hit_way  = array_if.hit_way & {NumWays{~snoop_rd_q}};

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      snoop_if.rdata[w]  = snoop_rd_q ? array_if.rdata[w] : '0;
      snoop_if.rflags[w] = snoop_rd_q ? array_if.rflags[w] : '0;
      fill_if.rdata[w]   = snoop_rd_q ? '0 : array_if.rdata[w];
      fill_if.rflags[w]  = snoop_rd_q ? '0 : array_if.rflags[w];
    end
  end

endmodule

/* src/cache_array.sv */
/*
 * Tag, flag and data storage of the set-associative line store.
 * A granted read returns hit_way, line data and flags of all ways one
 * cycle later. A granted write updates the masked ways at the grant edge.
 */
`timescale 1ns/1ps

module cache_array #(
  parameter int unsigned NumWays = snoop_cache_pkg::n_ways
) (
  input logic          clk_i,
  input logic          rst_ni,
  cache_port_if.arbiter port_i
);
  import snoop_cache_pkg::*;

  localparam int unsigned NumSets = 1 << index_w;

  logic [tag_w-1:0]  tag_mem  [NumWays][NumSets];
  logic [line_w-1:0] data_mem [NumWays][NumSets];
  line_flags_t       flags_q  [NumWays][NumSets];

  logic                           rd_en;
  logic                           wr_en;
  logic                           rvalid_q;
  logic [NumWays-1:0]             hit_q;
  logic [NumWays-1:0][line_w-1:0] rdata_q;
  line_flags_t [NumWays-1:0]      rflags_q;

  // single merged port, always ready
  assign port_i.gnt = port_i.req;
  assign rd_en = port_i.req & ~port_i.we;
  assign wr_en = port_i.req & port_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      for (int w = 0; w < NumWays; w++) begin
        for (int s = 0; s < NumSets; s++) begin
          flags_q[w][s] <= '0;
        end
      end
    end else begin
      rvalid_q <= rd_en;
      for (int w = 0; w < NumWays; w++) begin
        if (wr_en && port_i.way_mask[w]) begin
          flags_q[w][port_i.index] <= port_i.wflags;
        end
      end
    end
  end

  // line data and tags, only on full-line writes
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (wr_en && port_i.way_mask[w] && !port_i.data_only_flags) begin
        tag_mem[w][port_i.index]  <= port_i.tag;
        data_mem[w][port_i.index] <= port_i.wdata;
      end
    end
  end

  // lookup result, registered for one cycle
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      for (int w = 0; w < NumWays; w++) begin
        hit_q[w]    <= (tag_mem[w][port_i.index] == port_i.tag) &&
                       flags_q[w][port_i.index].valid;
        rdata_q[w]  <= data_mem[w][port_i.index];
        rflags_q[w] <= flags_q[w][port_i.index];
      end
    end
  end

  assign port_i.rvalid  = rvalid_q;
  assign port_i.hit_way = hit_q;
  assign port_i.rdata   = rdata_q;
  assign port_i.rflags  = rflags_q;

endmodule

/* src/cache_port_if.sv */
/*
 * Access port of one requester to the line store.
 * The requester modport drives the request fields, the arbiter
 * modport returns the grant and the registered lookup result.
 */
`timescale 1ns/1ps

interface cache_port_if #(
  parameter int unsigned NumWays = snoop_cache_pkg::n_ways
);
  import snoop_cache_pkg::*;

  logic                            req;
  logic                            we;
  logic [index_w-1:0]              index;
  logic [tag_w-1:0]                tag;
  logic [NumWays-1:0]              way_mask;
  logic [line_w-1:0]               wdata;
  line_flags_t                     wflags;
  // write flags only, keep line data and tag
  logic                            data_only_flags;
  logic                            gnt;
  logic                            rvalid;
  logic [NumWays-1:0]              hit_way;
  logic [NumWays-1:0][line_w-1:0]  rdata;
  line_flags_t [NumWays-1:0]       rflags;

  modport requester (
    output req, we, index, tag, way_mask, wdata, wflags, data_only_flags,
    input  gnt, rvalid, hit_way, rdata, rflags
  );

  modport arbiter (
    input  req, we, index, tag, way_mask, wdata, wflags, data_only_flags,
    output gnt, rvalid, hit_way, rdata, rflags
  );

endinterface

/* src/snoop_cache_pkg.sv */
/*
 * Shared definitions for the snooping data cache subsystem.
 * Holds the cache geometry, the snoop opcode encoding, the snoop
 * response layout and the per-line flag bits. Modules pull these in
 * by a wildcard import in their body.
 */
package snoop_cache_pkg;

  localparam int unsigned addr_w  = 32;
  localparam int unsigned index_w = 4;
  localparam int unsigned line_w  = 128;
  localparam int unsigned beat_w  = 64;
  // low 4 address bits select a byte in the 16-byte line
  localparam int unsigned tag_w   = addr_w - index_w - 4;
  localparam int unsigned n_ways  = 2;

  // ACE snoop encodings, anything else is unsupported
  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_INVALID = 4'b1001
  } snoop_op_e;

  // bit 0 is data_transfer, as on the CRRESP bus
  typedef struct packed {
    logic is_shared;
    logic pass_dirty;
    logic error;
    logic data_transfer;
  } cr_resp_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    logic shared;
  } line_flags_t;

endpackage
